/* sim.f */
+incdir+rtl
rtl/rob_pkg.sv
rtl/rob.sv
rtl/retire_stage.sv
rtl/branch_checkpoints.sv
rtl/rob_top.sv
bench/rob_tb_checks.sv
bench/rob_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = rob_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir

.PHONY: simulate clean

# A failing run ends in $fatal, so the binary's exit status fails the target
simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* bench/rob_tb.sv */
`timescale 1ns/10ps
`include "rob_params.svh"

module rob_tb;

    localparam int CYCLES = 2000;
    localparam int PERIOD = 8;

    logic                             clock;
    logic                             reset;
    rob_pkg::rob_entry_t [`ROB_N-1:0] rob_inputs;
    rob_pkg::slot_cnt_t               rob_inputs_valid;
    rob_pkg::complete_t  [`ROB_N-1:0] complete;
    logic                             resolve_valid;
    logic                             mispredict;
    rob_pkg::slot_cnt_t               rob_spots;
    logic [`BR_CNT_BITS-1:0]          branch_free;
    rob_pkg::rob_idx_t                tail;
    rob_pkg::rob_exit_t  [`ROB_N-1:0] rob_outputs;
    rob_pkg::slot_cnt_t               rob_outputs_valid;
    rob_pkg::retire_t    [`ROB_N-1:0] retired;
    rob_pkg::slot_cnt_t               retired_count;
    logic                             check_failed;

    int           seed;
    rob_pkg::pc_t next_pc;

    rob_top u_rob_top (.*);

    rob_tb_checks u_checks (
        .clock              (clock),
        .reset              (reset),
        .rob_inputs         (rob_inputs),
        .rob_inputs_valid   (rob_inputs_valid),
        .complete           (complete),
        .resolve_valid      (resolve_valid),
        .mispredict         (mispredict),
        .rob_spots          (rob_spots),
        .branch_free        (branch_free),
        .tail               (tail),
        .rob_outputs        (rob_outputs),
        .rob_outputs_valid  (rob_outputs_valid),
        .retired            (retired),
        .retired_count      (retired_count),
        .tail_restore_valid (u_rob_top.tail_restore_valid),
        .failed             (check_failed)
    );

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    function automatic int rand_below(input int limit);
        return ($random(seed) & 32'h7fff_ffff) % limit;
    endfunction

    // One cycle of legal stimulus, chosen from the model's view of the buffer
    task automatic drive_cycle(input int cyc);
        rob_pkg::rob_entry_t [`ROB_N-1:0] ins;
        rob_pkg::complete_t  [`ROB_N-1:0] cmp;
        int   open_idx[$];
        int   spots;
        int   free;
        int   cnt;
        int   nb;
        int   pos;
        int   pick;
        int   rate;
        logic younger_done;
        logic do_resolve;
        logic do_mis;
        ins        = '0;
        cmp        = '0;
        cnt        = 0;
        do_resolve = 1'b0;
        do_mis     = 1'b0;
        if (u_checks.ck_q.size() > 0 && rand_below(4) == 0) begin
            pos          = -1;
            younger_done = 1'b0;
            foreach (u_checks.q[j]) if (u_checks.q[j].pc == u_checks.ck_q[0].pc) pos = j;
            foreach (u_checks.q[j]) if (j > pos && u_checks.q[j].done) younger_done = 1'b1;
            if (pos < 0 || u_checks.q[pos].done) begin
                do_resolve = 1'b1;
                // Only a live branch with no younger completion flushes
                do_mis     = rand_below(3) == 0 && pos >= 0 && !younger_done;
            end
        end
        if (!do_mis) begin
            spots = `ROB_DEPTH - u_checks.q.size();
            if (spots > `ROB_N) spots = `ROB_N;
            free = `BR_DEPTH - u_checks.ck_q.size();
            cnt  = rand_below(spots + 1);
            nb   = 0;
            for (int i = 0; i < cnt; i++) begin
                ins[i].pc        = next_pc;
                ins[i].dest_arch = rob_pkg::arch_reg_t'($random(seed));
                ins[i].dest_phys = rob_pkg::phys_reg_t'($random(seed));
                next_pc          = next_pc + 4;
                if (nb < free && rand_below(4) == 0) begin
                    ins[i].is_branch = 1'b1;
                    nb++;
                end
            end
            foreach (u_checks.q[j]) if (!u_checks.q[j].done) open_idx.push_back(j);
            rate = ((cyc / 200) % 2 == 1) ? 8 : 2;   // Slow phases fill the buffer
            for (int i = 0; i < `ROB_N; i++) begin
                if (open_idx.size() > 0 && rand_below(rate) == 0) begin
                    pick       = rand_below(open_idx.size());
                    cmp[i].valid = 1'b1;
                    cmp[i].idx   = u_checks.q[open_idx[pick]].idx;
                    open_idx.delete(pick);
                end
            end
        end
        rob_inputs       <= ins;
        rob_inputs_valid <= rob_pkg::slot_cnt_t'(cnt);
        complete         <= cmp;
        resolve_valid    <= do_resolve;
        mispredict       <= do_mis;
    endtask

    always @(posedge check_failed) begin
        $display("TEST FAIL");
        $fatal(1, "A check on the ROB outputs failed");
    end

    // Twice the stimulus length
    initial begin
        #(2 * CYCLES * PERIOD);
        $display("TEST FAIL");
        $fatal(1, "Watchdog expired before the stimulus finished");
    end

    initial begin
        seed             = 32'h2463_9264;
        next_pc          = 32'h0000_1000;
        reset            = 1'b1;
        rob_inputs       = '0;
        rob_inputs_valid = '0;
        complete         = '0;
        resolve_valid    = 1'b0;
        mispredict       = 1'b0;
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        for (int c = 0; c < CYCLES; c++) begin
            @(posedge clock);
            drive_cycle(c);
        end
        repeat (3) @(posedge clock);   // Let the last retirements reach the checks
        if (check_failed) begin
            $display("TEST FAIL");
            $fatal(1, "Run ended with a failed check");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

/* bench/rob_tb_checks.sv */
`timescale 1ns/10ps
`include "rob_params.svh"

module rob_tb_checks (
    input  logic                             clock,
    input  logic                             reset,
    input  rob_pkg::rob_entry_t [`ROB_N-1:0] rob_inputs,
    input  rob_pkg::slot_cnt_t               rob_inputs_valid,
    input  rob_pkg::complete_t  [`ROB_N-1:0] complete,
    input  logic                             resolve_valid,
    input  logic                             mispredict,
    input  rob_pkg::slot_cnt_t               rob_spots,
    input  logic [`BR_CNT_BITS-1:0]          branch_free,
    input  rob_pkg::rob_idx_t                tail,
    input  rob_pkg::rob_exit_t  [`ROB_N-1:0] rob_outputs,
    input  rob_pkg::slot_cnt_t               rob_outputs_valid,
    input  rob_pkg::retire_t    [`ROB_N-1:0] retired,
    input  rob_pkg::slot_cnt_t               retired_count,
    input  logic                             tail_restore_valid,
    output logic                             failed
);

    typedef struct packed {
        rob_pkg::pc_t       pc;
        rob_pkg::arch_reg_t dest_arch;
        rob_pkg::phys_reg_t dest_phys;
        rob_pkg::rob_idx_t  idx;
        logic               is_branch;
        logic               done;
    } model_t;

    typedef struct packed {
        rob_pkg::pc_t      pc;
        rob_pkg::rob_idx_t idx;
    } ckpt_t;

    model_t q[$];      // Live entries in program order
    ckpt_t  ck_q[$];   // Unresolved branches, oldest first

    rob_pkg::rob_idx_t               tail_m;
    rob_pkg::slot_cnt_t              pend_cnt;
    rob_pkg::retire_t [`ROB_N-1:0]   pend;
    // Model snapshot for the current cycle checked at the next edge
    int                              occ_now;
    int                              free_now;
    int                              exp_spots;
    int                              exp_valid;
    rob_pkg::rob_idx_t               tail_now;
    rob_pkg::slot_cnt_t              exp_cnt;
    rob_pkg::retire_t [`ROB_N-1:0]   exp_rec;
    rob_pkg::rob_exit_t [`ROB_N-1:0] exp_win;

    initial failed = 1'b0;

    task automatic report_value(input string name, input logic [63:0] exp_v,
                                input logic [63:0] act_v);
        $display("FAIL %0t %s expected %0h actual %0h", $time, name, exp_v, act_v);
        failed = 1'b1;
    endtask

    // Mid-cycle update while the inputs for the coming edge are stable
    always @(negedge clock) begin : model_update
        int n;
        int p;
        occ_now   = q.size();
        free_now  = `BR_DEPTH - ck_q.size();
        exp_spots = (`ROB_DEPTH - occ_now < `ROB_N) ? `ROB_DEPTH - occ_now : `ROB_N;
        exp_valid = (occ_now < `ROB_N) ? occ_now : `ROB_N;
        tail_now  = tail_m;
        exp_cnt   = pend_cnt;
        exp_rec   = pend;
        exp_win   = '0;
        for (int i = 0; i < `ROB_N && i < q.size(); i++) begin
            exp_win[i] = '{entry: '{pc: q[i].pc, dest_arch: q[i].dest_arch,
                                    dest_phys: q[i].dest_phys, is_branch: q[i].is_branch},
                           complete: q[i].done};
        end
        if (reset) begin
            q.delete();
            ck_q.delete();
            tail_m   = '0;
            pend_cnt = '0;
            pend     = '0;
        end else begin
            n    = 0;
            pend = '0;
            while (n < `ROB_N && n < q.size() && q[n].done) begin
                pend[n] = '{pc: q[n].pc, dest_arch: q[n].dest_arch, dest_phys: q[n].dest_phys};
                n++;
            end
            pend_cnt = rob_pkg::slot_cnt_t'(n);
            for (int i = 0; i < `ROB_N; i++) begin
                if (complete[i].valid) begin
                    foreach (q[j]) if (q[j].idx == complete[i].idx) q[j].done = 1'b1;
                end
            end
            if (resolve_valid && mispredict && ck_q.size() > 0) begin
                p = -1;    // Branch already retired so every live entry is younger
                foreach (q[j]) if (q[j].pc == ck_q[0].pc) p = j;
                while (q.size() > p + 1) void'(q.pop_back());
                tail_m = ck_q[0].idx + 1'b1;
                ck_q.delete();
            end else begin
                if (resolve_valid && ck_q.size() > 0) void'(ck_q.pop_front());
                for (int i = 0; i < rob_inputs_valid; i++) begin
                    q.push_back('{pc: rob_inputs[i].pc, dest_arch: rob_inputs[i].dest_arch,
                                  dest_phys: rob_inputs[i].dest_phys,
                                  idx: tail_m + rob_pkg::rob_idx_t'(i),
                                  is_branch: rob_inputs[i].is_branch, done: 1'b0});
                    if (rob_inputs[i].is_branch) begin
                        ck_q.push_back('{pc: rob_inputs[i].pc,
                                         idx: tail_m + rob_pkg::rob_idx_t'(i)});
                    end
                end
                tail_m = tail_m + rob_pkg::rob_idx_t'(rob_inputs_valid);
            end
            for (int j = 0; j < n; j++) void'(q.pop_front());
        end
    end

    a_reset_state: assert property (@(posedge clock) $fell(reset) |->
        rob_outputs_valid == 0 && retired_count == 0 && !tail_restore_valid &&
        rob_spots == `ROB_N && branch_free == `BR_DEPTH)
        else begin
            $display("Outputs not in their reset state after reset at %0t", $time);
            failed = 1'b1;
        end

    a_retired_count: assert property (@(posedge clock) disable iff (reset)
        retired_count == exp_cnt)
        else report_value("retired_count", 64'($sampled(exp_cnt)), 64'($sampled(retired_count)));

    for (genvar g = 0; g < `ROB_N; g++) begin : g_records
        a_retired_record: assert property (@(posedge clock) disable iff (reset)
            retired_count > g |-> retired[g] == exp_rec[g])
            else report_value($sformatf("retired[%0d]", g), 64'($sampled(exp_rec[g])),
                              64'($sampled(retired[g])));
    end

    // Head window contents against the oldest live entries
    for (genvar g = 0; g < `ROB_N; g++) begin : g_window
        a_window_slot: assert property (@(posedge clock) disable iff (reset)
            g < occ_now |-> rob_outputs[g] == exp_win[g])
            else report_value($sformatf("rob_outputs[%0d]", g), 64'($sampled(exp_win[g])),
                              64'($sampled(rob_outputs[g])));
    end

    a_spots: assert property (@(posedge clock) disable iff (reset)
        int'(rob_spots) == exp_spots)
        else report_value("rob_spots", 64'($sampled(exp_spots)), 64'($sampled(rob_spots)));

    a_window: assert property (@(posedge clock) disable iff (reset)
        int'(rob_outputs_valid) == exp_valid)
        else report_value("rob_outputs_valid", 64'($sampled(exp_valid)),
                          64'($sampled(rob_outputs_valid)));

    a_tail: assert property (@(posedge clock) disable iff (reset) tail == tail_now)
        else report_value("tail", 64'($sampled(tail_now)), 64'($sampled(tail)));

    a_branch_free: assert property (@(posedge clock) disable iff (reset)
        int'(branch_free) == free_now)
        else report_value("branch_free", 64'($sampled(free_now)), 64'($sampled(branch_free)));

endmodule

/* rtl/rob_top.sv */
`timescale 1ns/10ps
`include "rob_params.svh"

module rob_top (
    input  logic                             clock,
    input  logic                             reset,

    input  rob_pkg::rob_entry_t [`ROB_N-1:0] rob_inputs,
    input  rob_pkg::slot_cnt_t               rob_inputs_valid,
    input  rob_pkg::complete_t  [`ROB_N-1:0] complete,
    input  logic                             resolve_valid,
    input  logic                             mispredict,

    output rob_pkg::slot_cnt_t               rob_spots,
    output logic [`BR_CNT_BITS-1:0]          branch_free,
    output rob_pkg::rob_idx_t                tail,           // Index handed to execution
    output rob_pkg::rob_exit_t  [`ROB_N-1:0] rob_outputs,
    output rob_pkg::slot_cnt_t               rob_outputs_valid,
    output rob_pkg::retire_t    [`ROB_N-1:0] retired,
    output rob_pkg::slot_cnt_t               retired_count
);

    rob_pkg::slot_cnt_t num_retiring;
    logic               tail_restore_valid;
    rob_pkg::rob_idx_t  tail_restore;

    rob u_rob (
        .clock              (clock),
        .reset              (reset),
        .rob_inputs         (rob_inputs),
        .rob_inputs_valid   (rob_inputs_valid),
        .complete           (complete),
        .num_retiring       (num_retiring),
        .tail_restore_valid (tail_restore_valid),
        .tail_restore       (tail_restore),
        .rob_spots          (rob_spots),
        .tail               (tail),
        .rob_outputs        (rob_outputs),
        .rob_outputs_valid  (rob_outputs_valid)
    );

    retire_stage u_retire_stage (
        .clock             (clock),
        .reset             (reset),
        .rob_outputs       (rob_outputs),
        .rob_outputs_valid (rob_outputs_valid),
        .num_retiring      (num_retiring),
        .retired           (retired),
        .retired_count     (retired_count)
    );

    // Sees the same dispatch as the ROB and the tail it lands on
    branch_checkpoints u_branch_checkpoints (
        .clock              (clock),
        .reset              (reset),
        .rob_inputs         (rob_inputs),
        .rob_inputs_valid   (rob_inputs_valid),
        .tail               (tail),
        .resolve_valid      (resolve_valid),
        .mispredict         (mispredict),
        .tail_restore_valid (tail_restore_valid),
        .tail_restore       (tail_restore),
        .branch_free        (branch_free)
    );

endmodule

/* rtl/branch_checkpoints.sv */
`timescale 1ns/10ps
`include "rob_params.svh"

module branch_checkpoints (
    input  logic                             clock,
    input  logic                             reset,

    input  rob_pkg::rob_entry_t [`ROB_N-1:0] rob_inputs,
    input  rob_pkg::slot_cnt_t               rob_inputs_valid,
    input  rob_pkg::rob_idx_t                tail,

    input  logic                             resolve_valid,  // Always the oldest checkpoint
    input  logic                             mispredict,

    output logic                             tail_restore_valid,
    output rob_pkg::rob_idx_t                tail_restore,
    output logic [`BR_CNT_BITS-1:0]          branch_free
);

    localparam int PTR_BITS = $clog2(`BR_DEPTH);

    typedef logic [PTR_BITS-1:0]     ptr_t;
    typedef logic [`BR_CNT_BITS-1:0] br_cnt_t;

    rob_pkg::rob_idx_t checkpoints [`BR_DEPTH];
    ptr_t    rd_ptr;
    ptr_t    wr_ptr;
    br_cnt_t count;

    rob_pkg::rob_idx_t [`ROB_N-1:0] push_val;   // Packed toward slot 0
    rob_pkg::slot_cnt_t             push_cnt;
    logic                           pop;

    assign tail_restore_valid = resolve_valid && mispredict;
    assign tail_restore       = checkpoints[rd_ptr];
    assign pop                = resolve_valid && !mispredict;
    assign branch_free        = br_cnt_t'(`BR_DEPTH) - count;

    // Each dispatched branch records the tail just past itself
    always_comb begin
        push_val = '0;
        push_cnt = '0;
        if (!tail_restore_valid) begin
            for (int i = 0; i < `ROB_N; i++) begin
                if (i < rob_inputs_valid && rob_inputs[i].is_branch) begin
                    push_val[push_cnt] = tail + rob_pkg::rob_idx_t'(i + 1);
                    push_cnt           = push_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int j = 0; j < `ROB_N; j++) begin
            if (j < push_cnt) begin
                checkpoints[wr_ptr + ptr_t'(j)] <= push_val[j];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (tail_restore_valid) begin
            // Every younger checkpoint is squashed with the branch
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + ptr_t'(push_cnt);
            rd_ptr <= rd_ptr + ptr_t'(pop);
            count  <= count + br_cnt_t'(push_cnt) - br_cnt_t'(pop);
        end
    end

    a_no_overflow: assert property (@(posedge clock) disable iff (reset)
        br_cnt_t'(push_cnt) <= branch_free + br_cnt_t'(pop))
        else $error("Checkpoint overflow, %0d pushes with %0d free", push_cnt, branch_free);

    a_resolve_needs_branch: assert property (@(posedge clock) disable iff (reset)
        resolve_valid |-> count != '0)
        else $error("Branch resolved with no checkpoint held");

endmodule

/* rtl/retire_stage.sv */
`timescale 1ns/10ps
`include "rob_params.svh"

module retire_stage (
    input  logic                             clock,
    input  logic                             reset,

    input  rob_pkg::rob_exit_t  [`ROB_N-1:0] rob_outputs,
    input  rob_pkg::slot_cnt_t               rob_outputs_valid,

    output rob_pkg::slot_cnt_t               num_retiring,   // Same cycle, back to the ROB
    output rob_pkg::retire_t    [`ROB_N-1:0] retired,
    output rob_pkg::slot_cnt_t               retired_count
);

    // Leading run of completed entries from the head
    always_comb begin
        num_retiring = '0;
        for (int i = 0; i < `ROB_N; i++) begin
            // Counting only continues while every older slot was taken
            if (i < rob_outputs_valid && rob_outputs[i].complete &&
                num_retiring == rob_pkg::slot_cnt_t'(i)) begin
                num_retiring = rob_pkg::slot_cnt_t'(i + 1);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            retired_count <= '0;
        end else begin
            retired_count <= num_retiring;
        end
    end

    // Records beyond the count are don't-care
    always_ff @(posedge clock) begin
        for (int i = 0; i < `ROB_N; i++) begin
            retired[i] <= '{pc:        rob_outputs[i].entry.pc,
                            dest_arch: rob_outputs[i].entry.dest_arch,
                            dest_phys: rob_outputs[i].entry.dest_phys};
        end
    end

    for (genvar g = 0; g < `ROB_N; g++) begin : g_retired_complete
        a_retired_complete: assert property (@(posedge clock) disable iff (reset)
            retired_count > g |->
                $past(rob_outputs[g].complete && rob_outputs_valid > g))
            else $error("Retired slot %0d was not a complete head entry", g);
    end

endmodule

/* rtl/rob.sv */
`timescale 1ns/10ps
`include "rob_params.svh"

module rob (
    input  logic                             clock,
    input  logic                             reset,

    input  rob_pkg::rob_entry_t [`ROB_N-1:0] rob_inputs,        // Oldest first
    input  rob_pkg::slot_cnt_t               rob_inputs_valid,  // Count of leading valid slots
    input  rob_pkg::complete_t  [`ROB_N-1:0] complete,

    input  rob_pkg::slot_cnt_t               num_retiring,      // Pops from the head this edge
    input  logic                             tail_restore_valid,
    input  rob_pkg::rob_idx_t                tail_restore,

    output rob_pkg::slot_cnt_t               rob_spots,         // Free entries, saturated at N
    output rob_pkg::rob_idx_t                tail,
    output rob_pkg::rob_exit_t  [`ROB_N-1:0] rob_outputs,       // Head window, head in slot 0
    output rob_pkg::slot_cnt_t               rob_outputs_valid
);

    typedef logic [`ROB_ENTRIES_BITS-1:0] entry_cnt_t;

    rob_pkg::rob_entry_t rob_entries [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0] done;     // Complete bit per slot

    rob_pkg::rob_idx_t head;
    rob_pkg::rob_idx_t next_head;
    rob_pkg::rob_idx_t next_tail;
    entry_cnt_t        entries;
    entry_cnt_t        next_entries;
    entry_cnt_t        kept;          // Occupancy after this cycle's pop
    entry_cnt_t        free_entries;
    rob_pkg::slot_cnt_t accepted;

    always_comb begin
        accepted     = tail_restore_valid ? '0 : rob_inputs_valid;  // Restore cycle drops dispatch
        next_head    = head + rob_pkg::rob_idx_t'(num_retiring);
        kept         = entries - entry_cnt_t'(num_retiring);
        free_entries = entry_cnt_t'(`ROB_DEPTH) - entries;

        if (tail_restore_valid) begin
            next_tail = tail_restore;
            // Nothing flushed when the checkpoint is the current tail, which also
            // covers a full buffer where head and tail coincide
            if (tail_restore == tail) begin
                next_entries = kept;
            end else begin
                next_entries = entry_cnt_t'(rob_pkg::rob_idx_t'(tail_restore - next_head));
            end
        end else begin
            next_tail    = tail + rob_pkg::rob_idx_t'(accepted);
            next_entries = kept + entry_cnt_t'(accepted);
        end

        rob_spots = (free_entries < `ROB_N) ? rob_pkg::slot_cnt_t'(free_entries)
                                            : rob_pkg::slot_cnt_t'(`ROB_N);
        rob_outputs_valid = (entries < `ROB_N) ? rob_pkg::slot_cnt_t'(entries)
                                               : rob_pkg::slot_cnt_t'(`ROB_N);

        for (int i = 0; i < `ROB_N; i++) begin
            if (i < rob_outputs_valid) begin
                rob_outputs[i] = '{entry:    rob_entries[head + rob_pkg::rob_idx_t'(i)],
                                   complete: done[head + rob_pkg::rob_idx_t'(i)]};
            end else begin
                rob_outputs[i] = '0;
            end
        end
    end

    // Entry payload
    always_ff @(posedge clock) begin
        for (int i = 0; i < `ROB_N; i++) begin
            if (i < accepted) begin
                rob_entries[tail + rob_pkg::rob_idx_t'(i)] <= rob_inputs[i];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head    <= '0;
            tail    <= '0;
            entries <= '0;
            done    <= '0;
        end else begin
            head    <= next_head;
            tail    <= next_tail;
            entries <= next_entries;
            for (int i = 0; i < `ROB_N; i++) begin
                if (complete[i].valid) begin
                    done[complete[i].idx] <= 1'b1;
                end
            end
            // Fresh entries start incomplete
            for (int i = 0; i < `ROB_N; i++) begin
                if (i < accepted) begin
                    done[tail + rob_pkg::rob_idx_t'(i)] <= 1'b0;
                end
            end
        end
    end

    a_dispatch_fits: assert property (@(posedge clock) disable iff (reset)
        rob_inputs_valid <= rob_spots)
        else $error("ROB dispatch of %0d entries with %0d spots", rob_inputs_valid, rob_spots);

    a_retire_in_window: assert property (@(posedge clock) disable iff (reset)
        num_retiring <= rob_outputs_valid)
        else $error("ROB pop of %0d entries beyond head window of %0d",
                    num_retiring, rob_outputs_valid);

    for (genvar g = 0; g < `ROB_N; g++) begin : g_complete_live
        // Offset from head must land inside the occupied range
        a_complete_live: assert property (@(posedge clock) disable iff (reset)
            complete[g].valid |->
                entry_cnt_t'(rob_pkg::rob_idx_t'(complete[g].idx - head)) < entries)
            else $error("ROB completion of idle entry %0d", complete[g].idx);
    end

endmodule

/* rtl/rob_pkg.sv */
`include "rob_params.svh"

package rob_pkg;

    // Plain vectors with a meaning of their own
    typedef logic [`ROB_IDX_BITS-1:0]  rob_idx_t;
    typedef logic [`ROB_CNT_BITS-1:0]  slot_cnt_t;   // Per-cycle slot count, not a mask
    typedef logic [`ARCH_REG_BITS-1:0] arch_reg_t;
    typedef logic [`PHYS_REG_BITS-1:0] phys_reg_t;
    typedef logic [`PC_BITS-1:0]       pc_t;

    // Written by dispatch into one ROB slot
    typedef struct packed {
        pc_t       pc;
        arch_reg_t dest_arch;
        phys_reg_t dest_phys;
        logic      is_branch;
    } rob_entry_t;

    // One slot of the head window seen by retire
    typedef struct packed {
        rob_entry_t entry;
        logic       complete;
    } rob_exit_t;

    // Completion strobe from an execution unit
    typedef struct packed {
        logic     valid;
        rob_idx_t idx;
    } complete_t;

    // Record reported for each retired instruction
    typedef struct packed {
        pc_t       pc;
        arch_reg_t dest_arch;
        phys_reg_t dest_phys;
    } retire_t;

endpackage

/* rtl/rob_params.svh */
`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

// Issue and retire width
`define ROB_N 3

// Reorder buffer geometry
// Depth must stay a power of two
`define ROB_DEPTH 16
`define ROB_IDX_BITS 4
`define ROB_CNT_BITS 2       // Holds 0..ROB_N
`define ROB_ENTRIES_BITS 5   // Holds 0..ROB_DEPTH

// Branch checkpoint queue
`define BR_DEPTH 4
`define BR_CNT_BITS 3        // Holds 0..BR_DEPTH

// Instruction fields
`define ARCH_REG_BITS 5
`define PHYS_REG_BITS 6
`define PC_BITS 32

`endif
